/* Bender.yml */
package:
  name: text_overlay

sources:
  - src/overlay_cfg_pkg.sv
  - src/glyph_pkg.sv
  - src/overlay_cfg_regs.sv
  - src/char_buffer_ram.sv
  - src/char_buf_reader.sv
  - src/text_overlay_top.sv
  - target: simulation
    files:
      - sim/text_overlay_checker.sv
      - sim/tb_text_overlay.sv

/* sim/tb_text_overlay.sv */
// ----------------------------------------------------------------------
// testbench for the text overlay source
// host writes geometry and strings while a reference model lists the
// expected glyph requests and a compare process checks every take
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_text_overlay
  import overlay_cfg_pkg::*, glyph_pkg::*;
();

  localparam int GLYPH_H    = 4;
  localparam int BUF_ADDR_W = 12;
  localparam int LEN_ADDR   = 1023;
  localparam int NUM_CASES  = 4;
  localparam int PASSES     = 2;

  localparam overlay_geom_t GEOM_DEFAULT = '{11'd10, 11'd10, 11'd10, 11'd20};
  localparam overlay_geom_t GEOM_A       = '{11'd16, 11'd32, 11'd8, 11'd12};
  localparam overlay_geom_t GEOM_B       = '{11'd100, 11'd200, 11'd12, 11'd24};

  logic                  clk = 1'b0;
  logic                  resetn;
  logic                  cfg_we;
  cfg_reg_e              cfg_sel;
  coord_t                cfg_wdata;
  logic                  buf_we;
  logic [BUF_ADDR_W-1:0] buf_waddr;
  logic [7:0]            buf_wdata;
  glyph_req_t            req;
  logic                  glyph_valid;
  logic                  char_next;

  glyph_req_t  expected_q [$];
  glyph_req_t  exp_req;
  logic [31:0] lfsr_state = 32'h274ca65d;

  // the last case changes geometry during its first pass
  string case_text [NUM_CASES] = '{"HELLO", "A B  C", "AB\nCD\015\nE\015F", "GEO"};
  overlay_geom_t case_geom_first [NUM_CASES] = '{GEOM_DEFAULT, GEOM_A, GEOM_DEFAULT, GEOM_A};
  overlay_geom_t case_geom_second [NUM_CASES] = '{GEOM_DEFAULT, GEOM_A, GEOM_DEFAULT, GEOM_B};

  always #4 clk = ~clk;

  text_overlay_top #(
    .BUF_ADDR_W   (BUF_ADDR_W),
    .LEN_ADDR     (LEN_ADDR),
    .GLYPH_HEIGHT (GLYPH_H)
  ) text_overlay_top_inst (
    .clk         (clk),
    .resetn      (resetn),
    .cfg_we      (cfg_we),
    .cfg_sel     (cfg_sel),
    .cfg_wdata   (cfg_wdata),
    .buf_we      (buf_we),
    .buf_waddr   (buf_waddr),
    .buf_wdata   (buf_wdata),
    .req         (req),
    .glyph_valid (glyph_valid),
    .char_next   (char_next)
  );

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_req(input glyph_req_t got, input glyph_req_t exp);
    if (got !== exp) begin
      report_failure($sformatf(
        "** Error: req got ascii=%h row=%h x=%h y=%h, expected ascii=%h row=%h x=%h y=%h",
        got.ascii, got.row, got.pos_x, got.pos_y, exp.ascii, exp.row, exp.pos_x, exp.pos_y));
    end
  endtask

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("** Error: glyph_valid got %h expected %h", got, exp));
    end
  endtask

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // reference model for one full pass of the string under geometry g
  function automatic void expand_text(input string text, input overlay_geom_t g,
                                      ref glyph_req_t q[$]);
    int         first [$];
    int         last [$];
    int         head;
    int         i;
    glyph_req_t r;
    head = 0;
    i = 0;
    while (i < text.len()) begin
      if (text[i] == ASCII_LF || text[i] == ASCII_CR) begin
        first.push_back(head);
        last.push_back(i);
        // CR-LF is a single break
        if (text[i] == ASCII_CR && i + 1 < text.len() && text[i+1] == ASCII_LF) begin
          i++;
        end
        i++;
        head = i;
      end else begin
        i++;
      end
    end
    first.push_back(head);
    last.push_back(text.len());
    foreach (first[ln]) begin
      for (int row = 0; row < GLYPH_H; row++) begin
        for (int k = first[ln]; k < last[ln]; k++) begin
          if (text[k] != ASCII_SPACE) begin
            r.ascii = text[k];
            r.row   = glyph_row_t'(row);
            r.pos_x = g.start_x + coord_t'((k - first[ln]) * g.char_w);
            r.pos_y = g.start_y + coord_t'(ln * g.char_h);
            q.push_back(r);
          end
        end
      end
    end
  endfunction

  task automatic write_cfg(input cfg_reg_e sel, input coord_t value);
    @(posedge clk);
    cfg_we    <= 1'b1;
    cfg_sel   <= sel;
    cfg_wdata <= value;
    @(posedge clk);
    cfg_we    <= 1'b0;
  endtask

  task automatic write_geom(input overlay_geom_t g);
    write_cfg(CFG_START_X, g.start_x);
    write_cfg(CFG_START_Y, g.start_y);
    write_cfg(CFG_CHAR_W, g.char_w);
    write_cfg(CFG_CHAR_H, g.char_h);
  endtask

  task automatic write_buf(input int addr, input logic [7:0] data);
    @(posedge clk);
    buf_we    <= 1'b1;
    buf_waddr <= BUF_ADDR_W'(addr);
    buf_wdata <= data;
    @(posedge clk);
    buf_we    <= 1'b0;
  endtask

  // high byte first
  task automatic write_length(input logic [15:0] len);
    write_buf(LEN_ADDR, len[15:8]);
    write_buf(LEN_ADDR + 1, len[7:0]);
  endtask

  // wait for a request, hold off 0 to 7 cycles, then pulse char_next
  task automatic take_one();
    int hold;
    hold = 0;
    @(posedge clk);
    while (!glyph_valid) begin
      @(posedge clk);
    end
    repeat (3) begin
      lfsr_state = lfsr_step(lfsr_state);
      hold = (hold << 1) | int'(lfsr_state[0]);
    end
    repeat (hold) @(posedge clk);
    char_next <= 1'b1;
    @(posedge clk);
    char_next <= 1'b0;
  endtask

  task automatic run_case(input string text, input overlay_geom_t g_first,
                          input overlay_geom_t g_second);
    int total;
    write_geom(g_first);
    for (int k = 0; k < text.len(); k++) begin
      write_buf(k, text[k]);
    end
    write_length(16'(text.len()));
    expand_text(text, g_first, expected_q);
    expand_text(text, g_second, expected_q);
    total = expected_q.size();
    for (int k = 0; k < total; k++) begin
      // zero length stops the walk after the final pass
      if (k == total - 1) begin
        write_length(16'd0);
      end
      take_one();
      if (k == 0 && g_second != g_first) begin
        write_geom(g_second);
      end
    end
    repeat (20) begin
      @(posedge clk);
      check_valid(glyph_valid, 1'b0);
    end
  endtask

  // ----------------------------------------------------------------------
  // compare on every take
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    if (resetn && glyph_valid && char_next) begin
      if (expected_q.size() == 0) begin
        report_failure("a request was taken while none was expected");
      end else begin
        exp_req = expected_q.pop_front();
        check_req(req, exp_req);
      end
    end
  end

  initial begin : stimulus
    resetn    = 1'b0;
    cfg_we    = 1'b0;
    cfg_sel   = CFG_START_X;
    cfg_wdata = '0;
    buf_we    = 1'b0;
    buf_waddr = '0;
    buf_wdata = '0;
    char_next = 1'b0;
    // empty string in the buffer while reset is held
    write_length(16'd0);
    repeat (4) @(posedge clk);
    resetn <= 1'b1;
    repeat (300) begin
      @(posedge clk);
      check_valid(glyph_valid, 1'b0);
    end
    for (int c = 0; c < NUM_CASES; c++) begin
      run_case(case_text[c], case_geom_first[c], case_geom_second[c]);
    end
    $display("All tests passed!");
    $finish;
  end

  initial begin : watchdog
    glyph_req_t scratch [$];
    int         budget;
    for (int c = 0; c < NUM_CASES; c++) begin
      expand_text(case_text[c], GEOM_DEFAULT, scratch);
    end
    budget = 200 * PASSES * scratch.size() + 2000;
    repeat (budget) @(posedge clk);
    report_failure($sformatf("run stalled, not finished after %0d cycles", budget));
  end

endmodule

/* sim/text_overlay_checker.sv */
// ----------------------------------------------------------------------
// protocol assertions on the glyph request port of the reader
// attached to every char_buf_reader instance by the bind below
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module text_overlay_checker
  import glyph_pkg::*;
#(
  parameter int GLYPH_HEIGHT = 18
) (
  input logic       clk,
  input logic       resetn,
  input glyph_req_t req,
  input logic       glyph_valid,
  input logic       char_next
);

  // nothing is offered straight out of reset
  valid_low_after_reset: assert property (@(posedge clk) !resetn |=> !glyph_valid)
    else $error("glyph_valid high in the cycle after reset");

  // a pending request is held until the renderer takes it
  req_held: assert property (@(posedge clk) disable iff (!resetn)
    glyph_valid && !char_next |=> glyph_valid && $stable(req))
    else $error("req changed or was dropped before char_next");

  row_in_glyph: assert property (@(posedge clk) disable iff (!resetn)
    glyph_valid |-> req.row < glyph_row_t'(GLYPH_HEIGHT))
    else $error("req.row beyond the last glyph row");

endmodule

bind char_buf_reader text_overlay_checker #(
  .GLYPH_HEIGHT (GLYPH_HEIGHT)
) checker_inst (
  .clk         (clk),
  .resetn      (resetn),
  .req         (req),
  .glyph_valid (glyph_valid),
  .char_next   (char_next)
);

/* src/char_buf_reader.sv */
// ----------------------------------------------------------------------
// walks the character buffer once per glyph pixel row and issues one
// glyph request per printable character, held until char_next
// spaces advance x, LF / CR-LF / lone CR end a text line
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module char_buf_reader
  import overlay_cfg_pkg::*, glyph_pkg::*;
#(
  parameter int BUF_ADDR_W   = 12,
  parameter int LEN_ADDR     = 1023,
  parameter int GLYPH_HEIGHT = 18
) (
  input  logic                  clk,
  input  logic                  resetn,

  input  overlay_geom_t         geom,

  // character buffer read port
  output logic [BUF_ADDR_W-1:0] buf_raddr,
  input  logic [7:0]            buf_rdata,

  // glyph request to the renderer
  output glyph_req_t            req,
  output logic                  glyph_valid,
  input  logic                  char_next
);

  reader_state_e         state;
  logic [2:0]            cnt;
  overlay_geom_t         geom_q;
  logic [15:0]           str_len;
  logic [BUF_ADDR_W-1:0] line_ptr;
  logic [BUF_ADDR_W-1:0] next_line;
  logic                  at_end;
  glyph_row_t            row;
  coord_t                cur_x;
  coord_t                cur_y;

  logic is_space;
  logic is_lf;
  logic is_cr;
  logic printable;
  logic last_char;
  logic last_row;

  // decode of the byte at buf_raddr
  assign is_space  = (buf_rdata == ASCII_SPACE);
  assign is_lf     = (buf_rdata == ASCII_LF);
  assign is_cr     = (buf_rdata == ASCII_CR);
  assign printable = !is_space && !is_lf && !is_cr;

  assign last_char = (16'(buf_raddr) == str_len - 16'd1);
  assign last_row  = (row == glyph_row_t'(GLYPH_HEIGHT - 1));

  // ----------------------------------------------------------------------
  // request payload and per-pass geometry
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (state == RD_READ_LEN && cnt == 3'd0) begin
      geom_q <= geom;
    end
    if (state == RD_SHOW && !glyph_valid && printable) begin
      req <= '{ascii: buf_rdata, row: row, pos_x: cur_x, pos_y: cur_y};
    end
  end

  // ----------------------------------------------------------------------
  // walk FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state       <= RD_READ_LEN;
      cnt         <= '0;
      buf_raddr   <= BUF_ADDR_W'(LEN_ADDR);
      glyph_valid <= 1'b0;
      str_len     <= '0;
      line_ptr    <= '0;
      next_line   <= '0;
      at_end      <= 1'b0;
      row         <= '0;
      cur_x       <= '0;
      cur_y       <= '0;
    end else begin
      case (state)
        // length bytes, high first, polled every five cycles while zero
        RD_READ_LEN: begin
          cnt <= cnt + 3'd1;
          case (cnt)
            3'd0: buf_raddr <= BUF_ADDR_W'(LEN_ADDR);
            3'd1: buf_raddr <= BUF_ADDR_W'(LEN_ADDR + 1);
            3'd2: begin
              str_len[15:8] <= buf_rdata;
              buf_raddr     <= '0;
            end
            3'd3: str_len[7:0] <= buf_rdata;
            default: begin
              cnt      <= '0;
              row      <= '0;
              line_ptr <= '0;
              cur_x    <= geom_q.start_x;
              cur_y    <= geom_q.start_y;
              if (str_len != 16'd0) begin
                state <= RD_SHOW;
              end
            end
          endcase
        end

        RD_SHOW: begin
          if (glyph_valid) begin
            // hold everything until the renderer takes the request
            if (char_next) begin
              glyph_valid <= 1'b0;
              if (last_char) begin
                at_end <= 1'b1;
                state  <= RD_LF;
              end else begin
                buf_raddr <= buf_raddr + 1'b1;
                cur_x     <= cur_x + geom_q.char_w;
                state     <= RD_WAIT;
              end
            end
          end else if (is_space) begin
            buf_raddr <= buf_raddr + 1'b1;
            cur_x     <= cur_x + geom_q.char_w;
            state     <= RD_WAIT;
          end else if (is_lf) begin
            next_line <= buf_raddr + 1'b1;
            at_end    <= 1'b0;
            state     <= RD_LF;
          end else if (is_cr) begin
            // peek at the next byte for a CR-LF pair
            buf_raddr <= buf_raddr + 1'b1;
            cnt       <= '0;
            state     <= RD_CR;
          end else begin
            glyph_valid <= 1'b1;
          end
        end

        // one cycle for the new address to reach buf_rdata
        RD_WAIT: begin
          state <= RD_SHOW;
        end

        RD_CR: begin
          if (cnt == 3'd0) begin
            cnt <= 3'd1;
          end else begin
            // a lone CR leaves the next line starting at the peeked byte
            next_line <= is_lf ? buf_raddr + 1'b1 : buf_raddr;
            at_end    <= 1'b0;
            state     <= RD_LF;
          end
        end

        // end of a text line, or of the string
        RD_LF: begin
          cur_x <= geom_q.start_x;
          if (!last_row) begin
            row       <= row + 1'b1;
            buf_raddr <= line_ptr;
            state     <= RD_WAIT;
          end else if (at_end) begin
            cnt       <= '0;
            buf_raddr <= BUF_ADDR_W'(LEN_ADDR);
            state     <= RD_READ_LEN;
          end else begin
            row       <= '0;
            cur_y     <= cur_y + geom_q.char_h;
            line_ptr  <= next_line;
            buf_raddr <= next_line;
            state     <= RD_WAIT;
          end
        end

        default: begin
          cnt   <= '0;
          state <= RD_READ_LEN;
        end
      endcase
    end
  end

endmodule

/* src/char_buffer_ram.sv */
// ----------------------------------------------------------------------
// character buffer, simple dual-port byte RAM
// host writes on one port, the reader reads with one cycle of latency
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module char_buffer_ram #(
  parameter int BUF_ADDR_W = 12
) (
  input  logic                  clk,

  // host write port
  input  logic                  buf_we,
  input  logic [BUF_ADDR_W-1:0] buf_waddr,
  input  logic [7:0]            buf_wdata,

  // reader port
  input  logic [BUF_ADDR_W-1:0] buf_raddr,
  output logic [7:0]            buf_rdata
);

  localparam int DEPTH = 2 ** BUF_ADDR_W;

  logic [7:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (buf_we) begin
      mem[buf_waddr] <= buf_wdata;
    end
  end

  // registered read, data follows the address by one cycle
  always_ff @(posedge clk) begin
    buf_rdata <= mem[buf_raddr];
  end

endmodule

/* src/glyph_pkg.sv */
// ----------------------------------------------------------------------
// character codes, reader states and the glyph request sent downstream
// the request carries screen coordinates from overlay_cfg_pkg
// ----------------------------------------------------------------------

package glyph_pkg;

  import overlay_cfg_pkg::*;

  // control characters the reader interprets
  localparam logic [7:0] ASCII_LF    = 8'h0A;
  localparam logic [7:0] ASCII_CR    = 8'h0D;
  localparam logic [7:0] ASCII_SPACE = 8'h20;

  // pixel row inside a glyph
  typedef logic [5:0] glyph_row_t;

  // one glyph row to render at a given cell
  typedef struct packed {
    logic [7:0] ascii;
    glyph_row_t row;
    coord_t     pos_x;
    coord_t     pos_y;
  } glyph_req_t;

  typedef enum logic [2:0] {
    RD_READ_LEN = 3'd0,
    RD_SHOW     = 3'd1,
    RD_WAIT     = 3'd2,
    RD_CR       = 3'd3,
    RD_LF       = 3'd4
  } reader_state_e;

endpackage

/* src/overlay_cfg_pkg.sv */
// ----------------------------------------------------------------------
// text geometry types shared by the register block and the reader
// import wherever an overlay_geom_t or a register name is needed
// ----------------------------------------------------------------------

package overlay_cfg_pkg;

  // pixel coordinate or size on screen
  typedef logic [10:0] coord_t;

  // geometry of the text block, latched by the reader once per pass
  typedef struct packed {
    coord_t start_x;
    coord_t start_y;
    // cell width in pixels
    coord_t char_w;
    // line pitch in pixels
    coord_t char_h;
  } overlay_geom_t;

  // host register select
  typedef enum logic [1:0] {
    CFG_START_X = 2'd0,
    CFG_START_Y = 2'd1,
    CFG_CHAR_W  = 2'd2,
    CFG_CHAR_H  = 2'd3
  } cfg_reg_e;

endpackage

/* src/overlay_cfg_regs.sv */
// ----------------------------------------------------------------------
// host-writable text geometry registers
// one register written per cfg_we strobe and visible the next cycle
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module overlay_cfg_regs
  import overlay_cfg_pkg::*;
(
  input  logic          clk,
  input  logic          resetn,

  // host write strobe
  input  logic          cfg_we,
  input  cfg_reg_e      cfg_sel,
  input  coord_t        cfg_wdata,

  // current geometry as sampled by the reader at the start of a pass
  output overlay_geom_t geom
);

  // default placement after reset
  localparam overlay_geom_t GEOM_RESET = '{
    start_x: 11'd10,
    start_y: 11'd10,
    char_w:  11'd10,
    char_h:  11'd20
  };

  always_ff @(posedge clk) begin
    if (!resetn) begin
      geom <= GEOM_RESET;
    end else if (cfg_we) begin
      case (cfg_sel)
        CFG_START_X: geom.start_x <= cfg_wdata;
        CFG_START_Y: geom.start_y <= cfg_wdata;
        CFG_CHAR_W:  geom.char_w  <= cfg_wdata;
        CFG_CHAR_H:  geom.char_h  <= cfg_wdata;
      endcase
    end
  end

endmodule

/* src/text_overlay_top.sv */
// ----------------------------------------------------------------------
// text overlay source, registers + character buffer + reader
// exposes the glyph request and char_next to the renderer
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module text_overlay_top
  import overlay_cfg_pkg::*, glyph_pkg::*;
#(
  parameter int BUF_ADDR_W   = 12,
  parameter int LEN_ADDR     = 1023,
  parameter int GLYPH_HEIGHT = 18
) (
  input  logic                  clk,
  input  logic                  resetn,

  // host geometry writes
  input  logic                  cfg_we,
  input  cfg_reg_e              cfg_sel,
  input  coord_t                cfg_wdata,

  // host buffer writes
  input  logic                  buf_we,
  input  logic [BUF_ADDR_W-1:0] buf_waddr,
  input  logic [7:0]            buf_wdata,

  // renderer side
  output glyph_req_t            req,
  output logic                  glyph_valid,
  input  logic                  char_next
);

  overlay_geom_t         geom;
  logic [BUF_ADDR_W-1:0] buf_raddr;
  logic [7:0]            buf_rdata;

  overlay_cfg_regs cfg_regs_inst (
    .clk       (clk),
    .resetn    (resetn),
    .cfg_we    (cfg_we),
    .cfg_sel   (cfg_sel),
    .cfg_wdata (cfg_wdata),
    .geom      (geom)
  );

  char_buffer_ram #(
    .BUF_ADDR_W (BUF_ADDR_W)
  ) char_buffer_ram_inst (
    .clk       (clk),
    .buf_we    (buf_we),
    .buf_waddr (buf_waddr),
    .buf_wdata (buf_wdata),
    .buf_raddr (buf_raddr),
    .buf_rdata (buf_rdata)
  );

  char_buf_reader #(
    .BUF_ADDR_W   (BUF_ADDR_W),
    .LEN_ADDR     (LEN_ADDR),
    .GLYPH_HEIGHT (GLYPH_HEIGHT)
  ) char_buf_reader_inst (
    .clk         (clk),
    .resetn      (resetn),
    .geom        (geom),
    .buf_raddr   (buf_raddr),
    .buf_rdata   (buf_rdata),
    .req         (req),
    .glyph_valid (glyph_valid),
    .char_next   (char_next)
  );

endmodule

/* text_overlay.f */
src/overlay_cfg_pkg.sv
src/glyph_pkg.sv
src/overlay_cfg_regs.sv
src/char_buffer_ram.sv
src/char_buf_reader.sv
src/text_overlay_top.sv
sim/text_overlay_checker.sv
sim/tb_text_overlay.sv
